// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/xosera_sim: xosera_lite.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module xosera_main_tb -f xosera_lite.f -o xosera_sim

run: obj_dir/xosera_sim
	./obj_dir/xosera_sim | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation ended without a result"; exit 1; }

lint:
	verilator --lint-only --timing --assert --top-module xosera_main_tb -f xosera_lite.f

clean:
	rm -rf obj_dir sim.log

// ==== source/color_lookup.sv ====
`default_nettype none
`timescale 1ns/1ps

module color_lookup(
    input  wire logic                   clk,
    input  wire logic                   xr_wr_i,        // xr write pulse
    input  wire xv_bus_pkg::xr_addr_u   xr_addr_i,
    input  wire xv_bus_pkg::word_t      xr_data_i,
    input  wire xv_video_pkg::color_t   color_index_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    input  wire logic                   dv_de_i,
    output xv_video_pkg::rgb_t          rgb_o,          // zero when not visible
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

xv_bus_pkg::word_t      color_mem [16]; // colour words, low 12 bits used
xv_bus_pkg::word_t      color_q;        // looked up colour
logic                   hsync_1;        // syncs one cycle in
logic                   vsync_1;
logic                   dv_de_1;
logic                   mem_wr;

assign mem_wr = xr_wr_i && xr_addr_i.mem.region;

// cpu side write port
always_ff @(posedge clk) begin
    if (mem_wr) begin
        color_mem[xr_addr_i.mem.color_index] <= xr_data_i;
    end
end

// stage 1, lookup
always_ff @(posedge clk) begin
    color_q <= color_mem[color_index_i];
    hsync_1 <= hsync_i;
    vsync_1 <= vsync_i;
    dv_de_1 <= dv_de_i;
end

// stage 2, blank and output
always_ff @(posedge clk) begin
    if (dv_de_1) begin
        rgb_o <= color_q[11:0];
    end else begin
        rgb_o <= '0;                    // black in borders
    end
    hsync_o <= hsync_1;
    vsync_o <= vsync_1;
    dv_de_o <= dv_de_1;
end

endmodule
`default_nettype wire

// ==== source/intr_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module intr_ctrl(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xv_bus_pkg::intr_t      intr_trigger_i, // one cycle per event
    input  wire xv_bus_pkg::intr_t      intr_mask_i,    // enabled sources
    input  wire xv_bus_pkg::intr_t      intr_clear_i,   // cpu acknowledge
    output xv_bus_pkg::intr_t           intr_status_o,  // pending bits
    output logic                        bus_intr_o      // cpu interrupt pulse
);

xv_bus_pkg::intr_t      new_intr;       // enabled and not yet pending

assign new_intr = intr_trigger_i & intr_mask_i & ~intr_status_o;

always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_intr_o      <= 1'b0;
        intr_status_o   <= '0;
    end else begin
        // only a fresh enabled event interrupts the cpu
        bus_intr_o      <= |new_intr;

        // any trigger is remembered, mask or not
        intr_status_o   <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
    end
end

endmodule
`default_nettype wire

// ==== source/reg_interface.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_interface(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // chip select, active low
    input  wire logic                   bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire logic [3:0]             bus_reg_num_i,  // register number
    input  wire logic                   bus_bytesel_i,  // 0 = even byte, 1 = odd byte
    input  wire xv_bus_pkg::byte_t      bus_data_i,
    output xv_bus_pkg::byte_t           bus_data_o,     // held until next read
    input  wire logic                   h_blank_i,
    input  wire logic                   v_blank_i,
    input  wire xv_bus_pkg::intr_t      intr_status_i,  // pending bits from intr_ctrl
    output xv_bus_pkg::intr_t           intr_mask_o,
    output xv_bus_pkg::intr_t           intr_clear_o,   // one cycle clear pulse
    output logic                        xr_wr_o,        // one cycle xr write pulse
    output xv_bus_pkg::xr_addr_u        xr_addr_o,
    output xv_bus_pkg::word_t           xr_data_o
);

logic                   cs_n_q;         // cs seen on previous clock
logic                   bus_strobe;     // first clock with cs low
logic                   wr_strobe;
logic                   rd_strobe;
xv_bus_pkg::byte_t      byte_hi;        // even byte waiting for its odd half
xv_bus_pkg::xr_addr_u   xr_addr;        // current xr address
xv_bus_pkg::intr_t      intr_mask;
xv_bus_pkg::byte_t      rd_byte;        // read mux result

assign bus_strobe   = cs_n_q & ~bus_cs_n_i;
assign wr_strobe    = bus_strobe & ~bus_rd_nwr_i;
assign rd_strobe    = bus_strobe & bus_rd_nwr_i;

assign xr_addr_o    = xr_addr;          // address stays put during the write pulse
assign intr_mask_o  = intr_mask;

// read data select
always_comb begin
    rd_byte = '0;
    case (bus_reg_num_i)
        xv_bus_pkg::REG_XR_ADDR: begin
            rd_byte = bus_bytesel_i ? xr_addr.raw[7:0] : xr_addr.raw[15:8];
        end
        xv_bus_pkg::REG_INT_CTRL: begin
            // even = mask, odd = pending
            rd_byte = bus_bytesel_i ? {6'b0, intr_status_i} : {6'b0, intr_mask};
        end
        xv_bus_pkg::REG_SYS_STATUS: begin
            if (!bus_bytesel_i) begin
                rd_byte = {v_blank_i, h_blank_i, 6'b0};
            end
        end
        default: begin
            rd_byte = '0;               // xr data reads not supported
        end
    endcase
end

// control state
always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_q          <= 1'b1;
        xr_wr_o         <= 1'b0;
        xr_addr         <= '0;
        intr_mask       <= '0;
        intr_clear_o    <= '0;
        bus_data_o      <= '0;
    end else begin
        cs_n_q          <= bus_cs_n_i;
        xr_wr_o         <= 1'b0;        // pulses last one cycle
        intr_clear_o    <= '0;

        // step address as the write pulse ends
        if (xr_wr_o) begin
            xr_addr.raw <= xr_addr.raw + 16'd1;
        end

        if (wr_strobe) begin
            if (!bus_bytesel_i) begin
                if (bus_reg_num_i == xv_bus_pkg::REG_INT_CTRL) begin
                    intr_mask <= bus_data_i[1:0];
                end
            end else begin
                case (bus_reg_num_i)
                    xv_bus_pkg::REG_XR_ADDR:  xr_addr.raw <= {byte_hi, bus_data_i};
                    xv_bus_pkg::REG_XR_DATA:  xr_wr_o <= 1'b1;
                    xv_bus_pkg::REG_INT_CTRL: intr_clear_o <= bus_data_i[1:0];
                    default: begin
                    end
                endcase
            end
        end

        if (rd_strobe) begin
            bus_data_o <= rd_byte;
        end
    end
end

// word assembly
always_ff @(posedge clk) begin
    if (wr_strobe && !bus_bytesel_i) begin
        byte_hi <= bus_data_i;          // high byte comes first
    end
    if (wr_strobe && bus_bytesel_i && bus_reg_num_i == xv_bus_pkg::REG_XR_DATA) begin
        xr_data_o <= {byte_hi, bus_data_i};
    end
end

endmodule
`default_nettype wire

// ==== source/video_timing.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_timing(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   xr_wr_i,        // xr write pulse
    input  wire xv_bus_pkg::xr_addr_u   xr_addr_i,
    input  wire xv_bus_pkg::word_t      xr_data_i,
    output logic                        hsync_o,        // active high
    output logic                        vsync_o,        // active high
    output logic                        dv_de_o,        // visible pixel
    output logic                        h_blank_o,
    output logic                        v_blank_o,
    output xv_video_pkg::color_t        color_index_o,  // test bar index
    output xv_bus_pkg::intr_t           intr_trigger_o
);

xv_video_pkg::hres_t    h_count;
xv_video_pkg::vres_t    v_count;
xv_video_pkg::vres_t    intr_line;      // XR_VID_INTR_LINE
logic                   line_start;     // first pixel of a line
logic                   reg_wr;         // register region write

assign line_start = (h_count == '0);
assign reg_wr     = xr_wr_i && !xr_addr_i.regs.region;

// counters and video register
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count     <= '0;
        v_count     <= '0;
        intr_line   <= '0;
    end else begin
        if (h_count == xv_video_pkg::H_TOTAL - 7'd1) begin
            h_count <= '0;
            if (v_count == xv_video_pkg::V_TOTAL - 4'd1) begin
                v_count <= '0;          // new frame
            end else begin
                v_count <= v_count + 4'd1;
            end
        end else begin
            h_count <= h_count + 7'd1;
        end

        if (reg_wr && xr_addr_i.regs.reg_num == xv_bus_pkg::XR_VID_INTR_LINE) begin
            intr_line <= xr_data_i[3:0];
        end
    end
end

// decode from counters
always_comb begin
    h_blank_o   = (h_count >= xv_video_pkg::H_VISIBLE);
    v_blank_o   = (v_count >= xv_video_pkg::V_VISIBLE);
    dv_de_o     = !h_blank_o && !v_blank_o;

    // sync after front porch
    hsync_o     = (h_count >= xv_video_pkg::H_VISIBLE + xv_video_pkg::H_FRONT) &&
                  (h_count <  xv_video_pkg::H_VISIBLE + xv_video_pkg::H_FRONT +
                              xv_video_pkg::H_SYNC);
    vsync_o     = (v_count >= xv_video_pkg::V_VISIBLE + xv_video_pkg::V_FRONT) &&
                  (v_count <  xv_video_pkg::V_VISIBLE + xv_video_pkg::V_FRONT +
                              xv_video_pkg::V_SYNC);

    color_index_o = h_count[xv_video_pkg::PIX_SHIFT +: 4];  // wraps every 16 bars

    intr_trigger_o = '0;
    intr_trigger_o[xv_bus_pkg::VIDEO_INTR]  = line_start && (v_count == intr_line);
    intr_trigger_o[xv_bus_pkg::VBLANK_INTR] = line_start &&
                                              (v_count == xv_video_pkg::V_VISIBLE);
end

endmodule
`default_nettype wire

// ==== source/xosera_main.sv ====
`default_nettype none
`timescale 1ns/1ps

module xosera_main(
    input  wire logic                   clk,            // pixel clock
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,     // chip select, active low
    input  wire logic                   bus_rd_nwr_i,   // 1 = read, 0 = write
    input  wire logic [3:0]             bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even, 1 = odd
    input  wire xv_bus_pkg::byte_t      bus_data_i,
    output xv_bus_pkg::byte_t           bus_data_o,
    output logic                        bus_intr_o,     // cpu interrupt pulse
    output logic [3:0]                  red_o,
    output logic [3:0]                  green_o,
    output logic [3:0]                  blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o         // display enable
);

// xr write bus, shared by timing and colour units
logic                   xr_wr;
xv_bus_pkg::xr_addr_u   xr_addr;
xv_bus_pkg::word_t      xr_data;

// interrupt signals
xv_bus_pkg::intr_t      intr_mask;
xv_bus_pkg::intr_t      intr_clear;
xv_bus_pkg::intr_t      intr_status;
xv_bus_pkg::intr_t      intr_trigger;

// raw video timing
logic                   hsync;
logic                   vsync;
logic                   dv_de;
logic                   h_blank;
logic                   v_blank;
xv_video_pkg::color_t   color_index;
xv_video_pkg::rgb_t     rgb;

assign {red_o, green_o, blue_o} = rgb;  // 4 bits per gun

reg_interface reg_interface(
    .clk(clk),
    .reset_i(reset_i),
    .bus_cs_n_i(bus_cs_n_i),
    .bus_rd_nwr_i(bus_rd_nwr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o),
    .h_blank_i(h_blank),
    .v_blank_i(v_blank),
    .intr_status_i(intr_status),
    .intr_mask_o(intr_mask),
    .intr_clear_o(intr_clear),
    .xr_wr_o(xr_wr),
    .xr_addr_o(xr_addr),
    .xr_data_o(xr_data)
);

intr_ctrl intr_ctrl(
    .clk(clk),
    .reset_i(reset_i),
    .intr_trigger_i(intr_trigger),
    .intr_mask_i(intr_mask),
    .intr_clear_i(intr_clear),
    .intr_status_o(intr_status),
    .bus_intr_o(bus_intr_o)
);

video_timing video_timing(
    .clk(clk),
    .reset_i(reset_i),
    .xr_wr_i(xr_wr),
    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de),
    .h_blank_o(h_blank),
    .v_blank_o(v_blank),
    .color_index_o(color_index),
    .intr_trigger_o(intr_trigger)
);

// 2 cycle lookup, syncs delayed to match
color_lookup color_lookup(
    .clk(clk),
    .xr_wr_i(xr_wr),
    .xr_addr_i(xr_addr),
    .xr_data_i(xr_data),
    .color_index_i(color_index),
    .hsync_i(hsync),
    .vsync_i(vsync),
    .dv_de_i(dv_de),
    .rgb_o(rgb),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .dv_de_o(dv_de_o)
);

endmodule
`default_nettype wire

// ==== source/xv_bus_pkg.sv ====
package xv_bus_pkg;

    typedef logic [15:0] word_t;            // 16-bit data word
    typedef logic [7:0]  byte_t;            // cpu bus byte
    typedef logic [1:0]  intr_t;            // one bit per video interrupt source

    // cpu register numbers
    localparam logic [3:0] REG_XR_ADDR    = 4'h0;  // xr address, auto increments
    localparam logic [3:0] REG_XR_DATA    = 4'h1;  // xr write data
    localparam logic [3:0] REG_INT_CTRL   = 4'h2;  // even mask, odd pending/clear
    localparam logic [3:0] REG_SYS_STATUS = 4'h3;  // blanking flags

    // interrupt bit positions
    localparam int VIDEO_INTR  = 0;         // interrupt line reached
    localparam int VBLANK_INTR = 1;         // first line of vertical blank

    // xr register numbers
    localparam logic [3:0] XR_VID_INTR_LINE = 4'h0;  // line that raises VIDEO_INTR

    // register view of an xr address
    typedef struct packed {
        logic        region;                // 0 = register
        logic [10:0] unused;
        logic [3:0]  reg_num;               // register number
    } xr_reg_view_t;

    // memory view of an xr address
    typedef struct packed {
        logic        region;                // 1 = colour memory
        logic [10:0] unused;
        logic [3:0]  color_index;           // colour entry
    } xr_mem_view_t;

    // one address word, decoded per region
    typedef union packed {
        xr_reg_view_t regs;
        xr_mem_view_t mem;
        word_t        raw;                  // plain word for loads and increment
    } xr_addr_u;

endpackage

// ==== source/xv_video_pkg.sv ====
package xv_video_pkg;

    typedef logic [6:0]  hres_t;            // horizontal count
    typedef logic [3:0]  vres_t;            // vertical count
    typedef logic [3:0]  color_t;           // colour memory index
    typedef logic [11:0] rgb_t;             // 4 bits each of r, g, b

    // horizontal timing in pixels
    localparam hres_t H_VISIBLE = 7'd64;
    localparam hres_t H_FRONT   = 7'd4;
    localparam hres_t H_SYNC    = 7'd8;
    localparam hres_t H_BACK    = 7'd4;
    localparam hres_t H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;  // 80

    // vertical timing in lines
    localparam vres_t V_VISIBLE = 4'd8;
    localparam vres_t V_FRONT   = 4'd1;
    localparam vres_t V_SYNC    = 4'd2;
    localparam vres_t V_BACK    = 4'd1;
    localparam vres_t V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;  // 12

    // test bars are 4 pixels wide
    localparam int PIX_SHIFT = 2;

endpackage

// ==== tb/xosera_main_asserts.sv ====
`timescale 1ns/1ps

module xosera_main_asserts(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_intr_i,
    input  logic [3:0]  red_i,
    input  logic [3:0]  green_i,
    input  logic [3:0]  blue_i,
    input  logic        hsync_i,
    input  logic        dv_de_i
);

// status blocks a repeat until cleared
intr_single: assert property (@(posedge clk) disable iff (reset_i)
    bus_intr_i |=> !bus_intr_i)
    else $error("bus interrupt high for two cycles in a row");

rgb_black: assert property (@(posedge clk) disable iff (reset_i)
    !dv_de_i |-> ({red_i, green_i, blue_i} == 12'h000))
    else $error("rgb not black outside display enable");

hsync_blank: assert property (@(posedge clk) disable iff (reset_i)
    hsync_i |-> !dv_de_i)
    else $error("hsync active inside the visible area");

endmodule

bind xosera_main xosera_main_asserts xosera_asserts(
    .clk(clk),
    .reset_i(reset_i),
    .bus_intr_i(bus_intr_o),
    .red_i(red_o),
    .green_i(green_o),
    .blue_i(blue_o),
    .hsync_i(hsync_o),
    .dv_de_i(dv_de_o)
);

// ==== tb/xosera_main_tb.sv ====
`timescale 1ns/1ps

module xosera_main_tb;

localparam int PIXELS_PER_LINE = int'(xv_video_pkg::H_VISIBLE);
localparam int LINES_PER_FRAME = int'(xv_video_pkg::V_VISIBLE);
localparam int LINES_TOTAL     = int'(xv_video_pkg::V_TOTAL);
localparam int SYNC_PIXELS     = int'(xv_video_pkg::H_SYNC);
localparam int FRAME_CYCLES    = int'(xv_video_pkg::H_TOTAL) * int'(xv_video_pkg::V_TOTAL);
localparam int TIMEOUT_CYCLES  = 8 * FRAME_CYCLES + 320;  // ~5 frames of tests plus reset and bus
localparam logic [3:0] INTR_LINE = 4'd5;                  // line for VIDEO_INTR

logic                   clk;
logic                   reset_i;
logic                   bus_cs_n_i;
logic                   bus_rd_nwr_i;
logic [3:0]             bus_reg_num_i;
logic                   bus_bytesel_i;
xv_bus_pkg::byte_t      bus_data_i;
xv_bus_pkg::byte_t      bus_data_o;
logic                   bus_intr_o;
logic [3:0]             red_o;
logic [3:0]             green_o;
logic [3:0]             blue_o;
logic                   hsync_o;
logic                   vsync_o;
logic                   dv_de_o;

integer                 seed = 17;
xv_bus_pkg::word_t      palette [16];   // model of the colour memory
logic                   cmp_en = 1'b0;  // pixel compare on, set by the test sequence
int                     cycle_count = 0;

// monitor state, all owned by the negedge process
logic                   de_prev = 1'b0;
logic                   hs_prev = 1'b0;
logic                   vs_prev = 1'b0;
logic                   intr_prev = 1'b0;
logic                   shape_armed = 1'b0;   // first vsync seen
logic                   in_vblank = 1'b0;     // frame position from dv_de and vsync
int                     col = 0;
int                     de_count = 0;
int                     hs_count = 0;
int                     hs_pulses = 0;        // hsync pulses since last vsync
int                     lines = 0;
int                     intr_count = 0;
int                     pix_checked = 0;
int                     frames_checked = 0;

xosera_main DUT(.*);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;             // 40 ns pixel clock
end

task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_rgb(input string name, input xv_video_pkg::rgb_t exp,
                         input xv_video_pkg::rgb_t act);
    if (act !== exp) begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        stop_run();
    end
endtask

task automatic check_byte(input string name, input xv_bus_pkg::byte_t exp,
                          input xv_bus_pkg::byte_t act);
    if (act !== exp) begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        stop_run();
    end
endtask

task automatic check_intr(input string name, input xv_bus_pkg::intr_t exp,
                          input xv_bus_pkg::intr_t act);
    if (act !== exp) begin
        $display("Fail %s: expected %b, actual %b", name, exp, act);
        stop_run();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        stop_run();
    end
endtask

// expected colour of one visible pixel, bars of 4 pixels wrapping every 16
function automatic xv_video_pkg::rgb_t ref_pixel(input xv_bus_pkg::word_t pal [16],
                                                 input int column);
    int                     bar;
    xv_video_pkg::color_t   idx;
    bar = (column >> xv_video_pkg::PIX_SHIFT) % 16;
    idx = bar[3:0];
    return pal[idx][11:0];              // upper nibble of the word unused
endfunction

task automatic bus_write(input logic [3:0] reg_num, input logic bytesel,
                         input xv_bus_pkg::byte_t data);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = reg_num;
    bus_bytesel_i = bytesel;
    bus_data_i    = data;
    repeat (2) @(negedge clk);          // cs low for two cycles
    bus_cs_n_i    = 1'b1;
endtask

task automatic bus_read(input logic [3:0] reg_num, input logic bytesel,
                        output xv_bus_pkg::byte_t data);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = reg_num;
    bus_bytesel_i = bytesel;
    @(negedge clk);
    data = bus_data_o;                  // loaded on the strobe clock
    @(negedge clk);
    bus_cs_n_i    = 1'b1;
endtask

task automatic write_word(input logic [3:0] reg_num, input xv_bus_pkg::word_t w);
    bus_write(reg_num, 1'b0, w[15:8]);  // even byte first, latched
    bus_write(reg_num, 1'b1, w[7:0]);
endtask

// lands just after the monitor has seen vsync_o rise
task automatic wait_vsync();
    @(posedge vsync_o);
    @(posedge clk);
endtask

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end
end

// compare process, outputs settle on posedge and are sampled here
always @(negedge clk) begin
    if (!reset_i) begin
        if (dv_de_o && !de_prev) begin
            col       = 0;              // column counted from de rise
            de_count  = 1;
            in_vblank = 1'b0;
        end else if (dv_de_o) begin
            col      = col + 1;
            de_count = de_count + 1;
        end
        if (!dv_de_o && de_prev) begin
            if (shape_armed) begin
                check_count("pixels per line", PIXELS_PER_LINE, de_count);
            end
            lines = lines + 1;
            if (lines == LINES_PER_FRAME) begin
                in_vblank = 1'b1;       // no visible lines left in this frame
            end
        end

        if (hsync_o && !hs_prev) begin
            hs_count = 1;
        end else if (hsync_o) begin
            hs_count = hs_count + 1;
        end
        if (!hsync_o && hs_prev && shape_armed) begin
            check_count("hsync cycles per line", SYNC_PIXELS, hs_count);
            hs_pulses = hs_pulses + 1;
        end

        if (vsync_o && !vs_prev) begin
            if (shape_armed) begin
                check_count("visible lines per frame", LINES_PER_FRAME, lines);
                check_count("hsync pulses per frame", LINES_TOTAL, hs_pulses);
                frames_checked = frames_checked + 1;
            end
            shape_armed = 1'b1;         // partial first frame skipped
            lines       = 0;
            hs_pulses   = 0;
        end

        if (bus_intr_o) begin
            if (intr_prev) begin
                $display("bus_intr_o stayed high for two cycles in a row");
                stop_run();
            end
            intr_count = intr_count + 1;
        end

        if (dv_de_o && cmp_en) begin
            check_rgb($sformatf("colour bar column %0d", col), ref_pixel(palette, col),
                      {red_o, green_o, blue_o});
            pix_checked = pix_checked + 1;
        end else if (!dv_de_o) begin
            check_rgb("border pixel", 12'h000, {red_o, green_o, blue_o});
        end
    end
    de_prev   = dv_de_o;
    hs_prev   = hsync_o;
    vs_prev   = vsync_o;
    intr_prev = bus_intr_o;
end

initial begin
    xv_bus_pkg::byte_t      rd;
    logic [31:0]            rnd;
    int                     start;
    logic                   exp_vb;
    xv_bus_pkg::xr_addr_u   color_addr;
    xv_bus_pkg::xr_addr_u   line_addr;
    xv_bus_pkg::word_t      end_addr;
    xv_bus_pkg::intr_t      mask;
    xv_bus_pkg::intr_t      both;

    reset_i       = 1'b1;
    bus_cs_n_i    = 1'b1;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;

    color_addr.raw           = '0;
    color_addr.mem.region    = 1'b1;    // colour memory, entry 0
    line_addr.raw            = '0;
    line_addr.regs.region    = 1'b0;
    line_addr.regs.reg_num   = xv_bus_pkg::XR_VID_INTR_LINE;
    mask                     = '0;
    mask[xv_bus_pkg::VIDEO_INTR]  = 1'b1;
    both                     = mask;
    both[xv_bus_pkg::VBLANK_INTR] = 1'b1;

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // colour memory through auto-increment
    write_word(xv_bus_pkg::REG_XR_ADDR, color_addr.raw);
    for (int i = 0; i < 16; i++) begin
        rnd = $random(seed);
        palette[i[3:0]] = rnd[15:0];
        write_word(xv_bus_pkg::REG_XR_DATA, palette[i[3:0]]);
    end
    end_addr = color_addr.raw + 16'd16;
    bus_read(xv_bus_pkg::REG_XR_ADDR, 1'b0, rd);
    check_byte("xr_addr high byte", end_addr[15:8], rd);
    bus_read(xv_bus_pkg::REG_XR_ADDR, 1'b1, rd);
    check_byte("xr_addr low byte", end_addr[7:0], rd);

    // line interrupt setup
    write_word(xv_bus_pkg::REG_XR_ADDR, line_addr.raw);
    write_word(xv_bus_pkg::REG_XR_DATA, {12'h000, INTR_LINE});
    bus_write(xv_bus_pkg::REG_INT_CTRL, 1'b0, {6'b0, mask});
    bus_read(xv_bus_pkg::REG_INT_CTRL, 1'b0, rd);
    check_intr("mask readback", mask, rd[1:0]);

    wait_vsync();
    cmp_en = 1'b1;                      // palette settled, full frames from here
    exp_vb = in_vblank;
    bus_read(xv_bus_pkg::REG_SYS_STATUS, 1'b0, rd);
    check_byte("sys_status in vsync", {exp_vb, 7'b0}, rd & 8'h80);
    bus_write(xv_bus_pkg::REG_INT_CTRL, 1'b1, 8'h03);
    start = intr_count;

    @(posedge dv_de_o);
    @(posedge clk);
    exp_vb = in_vblank;
    bus_read(xv_bus_pkg::REG_SYS_STATUS, 1'b0, rd);
    check_byte("sys_status in visible line", {exp_vb, 7'b0}, rd & 8'h80);

    // one pulse per frame while cleared every frame
    for (int f = 0; f < 2; f++) begin
        wait_vsync();
        check_count("interrupt pulses per frame", 1, intr_count - start);
        bus_read(xv_bus_pkg::REG_INT_CTRL, 1'b1, rd);
        check_intr("pending after a frame", both, rd[1:0]);
        bus_write(xv_bus_pkg::REG_INT_CTRL, 1'b1, 8'h03);
        start = intr_count;
    end

    bus_read(xv_bus_pkg::REG_INT_CTRL, 1'b1, rd);
    check_byte("pending after clear", 8'h00, rd);
    bus_write(xv_bus_pkg::REG_INT_CTRL, 1'b0, 8'h00);
    bus_read(xv_bus_pkg::REG_INT_CTRL, 1'b0, rd);
    check_byte("mask after clear", 8'h00, rd);
    start = intr_count;

    wait_vsync();
    check_count("interrupt pulses with mask off", 0, intr_count - start);
    bus_read(xv_bus_pkg::REG_INT_CTRL, 1'b1, rd);
    check_intr("pending with mask off", both, rd[1:0]);

    if (pix_checked < 2 * PIXELS_PER_LINE * LINES_PER_FRAME || frames_checked < 2) begin
        $display("too little video was checked: %0d pixels, %0d frames",
                 pix_checked, frames_checked);
        stop_run();
    end else begin
        $display("*** TEST PASSED ***");
        $finish;
    end
end

endmodule

// ==== xosera_lite.f ====
source/xv_bus_pkg.sv
source/xv_video_pkg.sv
source/reg_interface.sv
source/intr_ctrl.sv
source/video_timing.sv
source/color_lookup.sv
source/xosera_main.sv
tb/xosera_main_asserts.sv
tb/xosera_main_tb.sv
